/* hdl/MipsIsaPkg.sv */
`default_nettype none

package MipsIsaPkg;

    // Machine word and register index
    localparam int dataWidth      = 32;
    localparam int regAddrWidth   = 5;
    localparam int regCount       = 1 << regAddrWidth; // Architectural registers

    // Instruction field widths
    localparam int opcodeWidth    = 6;
    localparam int functWidth     = 6;
    localparam int immWidth       = 16; // I-format immediate
    localparam int jumpIndexWidth = 26; // J-format target index

    // Primary opcode, instr[31:26]
    typedef enum logic [opcodeWidth-1:0] {
        rFormat     = 6'b000000, // Register-register ops
        jump        = 6'b000010,
        branchEqual = 6'b000100,
        addi        = 6'b001000,
        loadWord    = 6'b100011,
        storeWord   = 6'b101011
    } opcodeT;

    // R-format funct field, instr[5:0]
    typedef enum logic [functWidth-1:0] {
        functAdd = 6'b100000,
        functSub = 6'b100010,
        functAnd = 6'b100100,
        functOr  = 6'b100101,
        functSlt = 6'b101010  // Signed compare
    } functT;

endpackage

`default_nettype wire

/* hdl/MipsCtrlPkg.sv */
`default_nettype none

package MipsCtrlPkg;

    // Operation class from the main decoder, same bit pattern as ALUOp1/ALUOp0
    typedef enum logic [1:0] {
        addOp   = 2'b00, // Address calc and addi
        subOp   = 2'b01, // Compare for beq
        functOp = 2'b10  // Let funct decide
    } aluOpT;

    // Function actually performed by the ALU
    typedef enum logic [2:0] {
        aluAnd = 3'b000,
        aluOr  = 3'b001,
        aluAdd = 3'b010,
        aluSub = 3'b110,
        aluSlt = 3'b111
    } aluFuncT;

endpackage

`default_nettype wire

/* hdl/ControlIf.sv */
`timescale 1ns/100ps
`default_nettype none

interface ControlIf;
    import MipsCtrlPkg::*;

    logic  regDst;   // Write rd instead of rt
    logic  aluSrc;   // Immediate as ALU operand B
    logic  memToReg; // Write back load data
    logic  regWrite;
    logic  memRead;
    logic  memWrite;
    logic  branch;
    logic  jump;
    aluOpT aluOp;

    modport decoder (
        output regDst, aluSrc, memToReg, regWrite,
        output memRead, memWrite, branch, jump, aluOp
    );

    modport datapath (
        input regDst, aluSrc, memToReg, regWrite,
        input memRead, memWrite, branch, jump, aluOp
    );

endinterface

`default_nettype wire

/* hdl/ControlUnit.sv */
`timescale 1ns/100ps
`default_nettype none

module ControlUnit (
    input  MipsIsaPkg::opcodeT opcode,
    ControlIf.decoder          ctrl
);
    import MipsIsaPkg::*;
    import MipsCtrlPkg::*;

    always_comb begin
        // Everything off by default, so unknown opcodes act as no-ops
        ctrl.regDst   = 1'b0;
        ctrl.aluSrc   = 1'b0;
        ctrl.memToReg = 1'b0;
        ctrl.regWrite = 1'b0;
        ctrl.memRead  = 1'b0;
        ctrl.memWrite = 1'b0;
        ctrl.branch   = 1'b0;
        ctrl.jump     = 1'b0;
        ctrl.aluOp    = addOp;

        case (opcode)
            rFormat: begin
                ctrl.regDst   = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = functOp; // Funct picks the operation
            end

            addi: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end

            jump: begin
                ctrl.jump = 1'b1; // Rest is don't care
            end

            loadWord: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
            end

            storeWord: begin
                ctrl.regDst   = 1'b1; // Don't care
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1; // Don't care
                ctrl.memWrite = 1'b1;
            end

            branchEqual: begin
                ctrl.regDst   = 1'b1; // Don't care
                ctrl.memToReg = 1'b1; // Don't care
                ctrl.branch   = 1'b1;
                ctrl.aluOp    = subOp;
            end

            default: ; // Unknown opcode keeps the cleared bundle
        endcase
    end

endmodule

`default_nettype wire

/* hdl/AluControl.sv */
`timescale 1ns/100ps
`default_nettype none

module AluControl (
    input  MipsCtrlPkg::aluOpT                aluOp,
    input  logic [MipsIsaPkg::functWidth-1:0] funct,
    output MipsCtrlPkg::aluFuncT              aluFunc
);
    import MipsIsaPkg::*;
    import MipsCtrlPkg::*;

    always_comb begin
        case (aluOp)
            addOp: aluFunc = aluAdd; // lw, sw, addi
            subOp: aluFunc = aluSub; // beq compares by subtracting
            functOp: begin
                case (functT'(funct))
                    functAdd: aluFunc = aluAdd;
                    functSub: aluFunc = aluSub;
                    functAnd: aluFunc = aluAnd;
                    functOr:  aluFunc = aluOr;
                    functSlt: aluFunc = aluSlt;
                    default:  aluFunc = aluAdd; // Unsupported funct
                endcase
            end
            default: aluFunc = aluAdd;
        endcase
    end

endmodule

`default_nettype wire

/* hdl/Alu.sv */
`timescale 1ns/100ps
`default_nettype none

module Alu (
    input  MipsCtrlPkg::aluFuncT              aluFunc,
    input  logic [MipsIsaPkg::dataWidth-1:0] a,
    input  logic [MipsIsaPkg::dataWidth-1:0] b,
    output logic [MipsIsaPkg::dataWidth-1:0] result,
    output logic                             zero
);
    import MipsIsaPkg::*;
    import MipsCtrlPkg::*;

    logic lessThan;

    assign lessThan = $signed(a) < $signed(b); // Two's complement compare

    always_comb begin
        case (aluFunc)
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluAdd:  result = a + b;
            aluSub:  result = a - b;
            aluSlt:  result = {{(dataWidth-1){1'b0}}, lessThan};
            default: result = a + b;
        endcase
    end

    // Used by beq after a subtract
    assign zero = (result == '0);

endmodule

`default_nettype wire

/* hdl/RegisterFile.sv */
`timescale 1ns/100ps
`default_nettype none

module RegisterFile (
    input  logic                                clock,
    input  logic                                reset,
    input  logic [MipsIsaPkg::regAddrWidth-1:0] readAddrA,
    input  logic [MipsIsaPkg::regAddrWidth-1:0] readAddrB,
    input  logic [MipsIsaPkg::regAddrWidth-1:0] writeAddr,
    input  logic [MipsIsaPkg::dataWidth-1:0]    writeData,
    input  logic                                writeEnable,
    output logic [MipsIsaPkg::dataWidth-1:0]    readDataA,
    output logic [MipsIsaPkg::dataWidth-1:0]    readDataB
);
    import MipsIsaPkg::*;

    logic [dataWidth-1:0] regs [regCount];

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (writeAddr != '0)) begin // $zero is read-only
            regs[writeAddr] <= writeData;
        end
    end

    // Asynchronous reads
    assign readDataA = regs[readAddrA];
    assign readDataB = regs[readAddrB];

endmodule

`default_nettype wire

/* hdl/MipsCore.sv */
`timescale 1ns/100ps
`default_nettype none

module MipsCore (
    input  logic                             clock,
    input  logic                             reset,
    output logic [MipsIsaPkg::dataWidth-1:0] instrAddr,
    input  logic [MipsIsaPkg::dataWidth-1:0] instr,
    output logic [MipsIsaPkg::dataWidth-1:0] dataAddr,
    output logic [MipsIsaPkg::dataWidth-1:0] writeData,
    input  logic [MipsIsaPkg::dataWidth-1:0] readData,
    output logic                             memRead,
    output logic                             memWrite
);
    import MipsIsaPkg::*;
    import MipsCtrlPkg::*;

    logic [dataWidth-1:0]      pc;
    logic [dataWidth-1:0]      pcPlus4;
    logic [dataWidth-1:0]      branchTarget;
    logic [dataWidth-1:0]      jumpTarget;
    logic [dataWidth-1:0]      nextPc;
    logic [regAddrWidth-1:0]   rs;
    logic [regAddrWidth-1:0]   rt;
    logic [regAddrWidth-1:0]   rd;
    logic [regAddrWidth-1:0]   writeReg;
    logic [functWidth-1:0]     funct;
    logic [immWidth-1:0]       imm;
    logic [jumpIndexWidth-1:0] jumpIndex;
    logic [dataWidth-1:0]      signImm;
    logic [dataWidth-1:0]      readDataA;
    logic [dataWidth-1:0]      readDataB;
    logic [dataWidth-1:0]      aluB;
    logic [dataWidth-1:0]      aluResult;
    logic [dataWidth-1:0]      writeBack;
    logic                      aluZero;
    logic                      regWriteEn;
    aluFuncT                   aluFunc;

    ControlIf ctrl();

    // Instruction fields
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign funct     = instr[5:0];
    assign imm       = instr[15:0];
    assign jumpIndex = instr[25:0];
    assign signImm   = {{(dataWidth-immWidth){imm[immWidth-1]}}, imm};

    // Program counter
    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= nextPc;
        end
    end

    assign instrAddr    = pc;
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {signImm[dataWidth-3:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00}; // Stay in 256 MB region

    always_comb begin
        if (ctrl.jump) begin
            nextPc = jumpTarget;
        end else if (ctrl.branch && aluZero) begin // beq taken
            nextPc = branchTarget;
        end else begin
            nextPc = pcPlus4;
        end
    end

    // Datapath muxes
    assign writeReg  = ctrl.regDst ? rd : rt;
    assign aluB      = ctrl.aluSrc ? signImm : readDataB;
    assign writeBack = ctrl.memToReg ? readData : aluResult;

    // No side effects while in reset
    assign regWriteEn = ctrl.regWrite & ~reset;
    assign memRead    = ctrl.memRead & ~reset;
    assign memWrite   = ctrl.memWrite & ~reset;
    assign dataAddr   = aluResult;
    assign writeData  = readDataB; // sw stores rt

    ControlUnit controlUnit (
        .opcode (opcodeT'(instr[31:26])),
        .ctrl   (ctrl.decoder)
    );

    AluControl aluControl (
        .aluOp   (ctrl.aluOp),
        .funct   (funct),
        .aluFunc (aluFunc)
    );

    Alu alu (
        .aluFunc (aluFunc),
        .a       (readDataA),
        .b       (aluB),
        .result  (aluResult),
        .zero    (aluZero)
    );

    RegisterFile registerFile (
        .clock       (clock),
        .reset       (reset),
        .readAddrA   (rs),
        .readAddrB   (rt),
        .writeAddr   (writeReg),
        .writeData   (writeBack),
        .writeEnable (regWriteEn),
        .readDataA   (readDataA),
        .readDataB   (readDataB)
    );

endmodule

`default_nettype wire

/* verif/ClockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module ClockGen (
    output logic clock,
    output logic reset
);
    localparam int halfPeriod  = 10; // 20 ns period
    localparam int resetCycles = 2;

    initial begin
        clock = 1'b0;
        reset = 1'b1; // Core held until the first pulse
        forever #halfPeriod clock = ~clock;
    end

    // Reset changes on falling edges and covers resetCycles rising edges
    task automatic pulseReset();
        @(negedge clock);
        reset <= 1'b1;
        repeat (resetCycles) @(negedge clock);
        reset <= 1'b0;
    endtask

endmodule

`default_nettype wire

/* verif/MipsCoreTb.sv */
`timescale 1ns/100ps
`default_nettype none

module MipsCoreTb;
    import MipsIsaPkg::*;

    localparam int cycleLimit = 400; // Tests need about 60 cycles

    logic        clock;
    logic        reset;
    logic [31:0] instrAddr;
    logic [31:0] instr;
    logic [31:0] dataAddr;
    logic [31:0] writeData;
    logic [31:0] readData;
    logic        memRead;
    logic        memWrite;
    logic        logEnable = 1'b0;
    logic [31:0] instrMem [256];
    logic [31:0] dataMem [256];
    logic [31:0] pcTrace [$];
    logic [31:0] storeAddrs [$];
    logic [31:0] storeData [$];
    logic [31:0] loadAddrs [$];
    int          tracedCount = 0;
    int          cycleCount = 0;
    integer      seed = 93;

    ClockGen clockGen (.*);

    MipsCore UUT (.*);

    assign instr = instrMem[instrAddr[9:2]]; // Combinational fetch

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Run aborted");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error: %s expected %h, got %h", name, expected, actual);
            abortRun("Stopping at the first mismatch");
        end
    endtask

    task automatic expectStore(input int index, input logic [31:0] addr, input logic [31:0] data);
        checkValue("dataAddr", addr, storeAddrs[index]);
        checkValue("writeData", data, storeData[index]);
    endtask

    function automatic logic [31:0] rType(functT fn, logic [4:0] rd, logic [4:0] rs,
                                          logic [4:0] rt);
        return {rFormat, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iType(logic [5:0] op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jType(logic [25:0] index);
        return {jump, index};
    endfunction

    // Memory side of the core, sampled mid-cycle where outputs are settled
    always @(negedge clock) begin
        cycleCount++;
        if (cycleCount > cycleLimit) begin
            abortRun("Timeout: the tests did not finish within the cycle limit");
        end
        if (reset) begin
            checkValue("memWrite", 32'd0, memWrite); // Strobes gated in reset
            checkValue("memRead", 32'd0, memRead);
        end else if (logEnable) begin
            pcTrace.push_back(instrAddr);
            if (memRead) begin
                loadAddrs.push_back(dataAddr);
            end
            if (memWrite) begin
                storeAddrs.push_back(dataAddr);
                storeData.push_back(writeData);
                dataMem[dataAddr[9:2]] = writeData;
            end
            tracedCount++;
        end
        readData <= dataMem[dataAddr[9:2]];
    end

    task automatic prepareRun();
        logEnable = 1'b0; // Old program runs on unobserved
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = '0; // All-zero word is a harmless R-format op
        end
    endtask

    task automatic releaseCore();
        clockGen.pulseReset();
        pcTrace.delete();
        storeAddrs.delete();
        storeData.delete();
        loadAddrs.delete();
        tracedCount = 0;
        checkValue("instrAddr", 32'd0, instrAddr); // First cycle out of reset
        logEnable = 1'b1;
    endtask

    task automatic runInstructions(input int count);
        wait (tracedCount >= count);
    endtask

    task automatic arithmeticOps();
        logic [15:0] immA;
        logic [15:0] immB;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected [5];
        immA = $random(seed);
        immB = $random(seed);
        a = {{16{immA[15]}}, immA};
        b = {{16{immB[15]}}, immB};
        expected[0] = a + b;
        expected[1] = a - b;
        expected[2] = a & b;
        expected[3] = a | b;
        expected[4] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        prepareRun();
        instrMem[1] = iType(addi, 0, 1, immA);
        instrMem[2] = iType(addi, 0, 2, immB);
        instrMem[3] = rType(functAdd, 3, 1, 2);
        instrMem[4] = rType(functSub, 4, 1, 2);
        instrMem[5] = rType(functAnd, 5, 1, 2);
        instrMem[6] = rType(functOr, 6, 1, 2);
        instrMem[7] = rType(functSlt, 7, 1, 2);
        instrMem[8] = iType(addi, 0, 8, 16'h0040); // Store base
        for (int i = 0; i < 5; i++) begin
            instrMem[9 + i] = iType(storeWord, 8, 3 + i, 4 * i);
        end
        releaseCore();
        runInstructions(13);
        checkValue("store count", 32'd5, storeAddrs.size());
        for (int i = 0; i < 5; i++) begin
            expectStore(i, 32'h40 + 4 * i, expected[i]);
        end
    endtask

    task automatic loadAndStore();
        logic [31:0] preload;
        logic [15:0] imm;
        preload = $random(seed);
        imm = $random(seed);
        prepareRun();
        dataMem[32] = preload; // Byte address 0x80
        instrMem[1] = iType(addi, 0, 1, 16'h0060);
        instrMem[2] = iType(addi, 0, 2, imm);
        instrMem[3] = iType(storeWord, 1, 2, 16'h0008);
        instrMem[4] = iType(loadWord, 1, 3, 16'h0020);
        instrMem[5] = iType(storeWord, 1, 3, 16'h000C);
        releaseCore();
        runInstructions(5);
        checkValue("load count", 32'd1, loadAddrs.size());
        checkValue("dataAddr", 32'h80, loadAddrs[0]);
        checkValue("store count", 32'd2, storeAddrs.size());
        expectStore(0, 32'h68, {{16{imm[15]}}, imm});
        expectStore(1, 32'h6C, preload);
    endtask

    task automatic beqPaths();
        prepareRun();
        instrMem[1] = iType(addi, 0, 1, 16'd5);
        instrMem[2] = iType(addi, 0, 2, 16'd5);
        instrMem[3] = iType(branchEqual, 1, 2, 16'd2); // Equal, skips two words
        instrMem[4] = iType(storeWord, 0, 1, 16'h0000);
        instrMem[5] = iType(storeWord, 0, 1, 16'h0004);
        instrMem[6] = iType(addi, 0, 3, 16'd7);
        instrMem[7] = iType(branchEqual, 1, 3, 16'd5); // Unequal, falls through
        instrMem[8] = iType(storeWord, 0, 3, 16'h0008);
        releaseCore();
        runInstructions(6);
        checkValue("instrAddr", 32'd12 + 32'd4 + (32'd2 << 2), pcTrace[3]);
        checkValue("instrAddr", 32'd28 + 32'd4, pcTrace[5]);
        checkValue("store count", 32'd1, storeAddrs.size());
        expectStore(0, 32'h8, 32'd7);
    endtask

    task automatic jumpTarget();
        logic [25:0] index;
        index = 26'd10;
        prepareRun();
        instrMem[1] = jType(index); // j sits at 0x4
        for (int i = 2; i < 10; i++) begin
            instrMem[i] = iType(storeWord, 0, 0, 4 * i); // Jumped over
        end
        instrMem[10] = iType(addi, 0, 1, 16'h0033);
        instrMem[11] = iType(storeWord, 0, 1, 16'h0010);
        releaseCore();
        runInstructions(3);
        checkValue("instrAddr", 32'd4 * index, pcTrace[1]); // Upper PC bits are zero here
        checkValue("store count", 32'd1, storeAddrs.size());
        expectStore(0, 32'h10, 32'h33);
    endtask

    task automatic noOpAndZeroReg();
        prepareRun();
        instrMem[1] = iType(addi, 0, 1, 16'h1234);
        instrMem[2] = iType(6'b111111, 0, 1, 16'h0055); // Undefined opcode
        instrMem[3] = iType(storeWord, 0, 1, 16'h0020);
        instrMem[4] = iType(addi, 0, 0, 16'h0077);
        instrMem[5] = iType(storeWord, 0, 0, 16'h0024);
        releaseCore();
        runInstructions(5);
        checkValue("instrAddr", 32'd8 + 32'd4, pcTrace[2]);
        checkValue("store count", 32'd2, storeAddrs.size());
        expectStore(0, 32'h20, 32'h1234);
        expectStore(1, 32'h24, 32'h0);
    endtask

    task automatic resetBehavior();
        prepareRun();
        instrMem[0] = iType(storeWord, 0, 0, 16'h0030); // At the reset vector
        releaseCore();
        prepareRun();
        instrMem[0] = iType(loadWord, 0, 1, 16'h0030);
        releaseCore();
        runInstructions(2);
        checkValue("instrAddr", 32'd8, pcTrace[1]);
    endtask

    initial begin
        readData = '0;
        for (int i = 0; i < 256; i++) begin
            instrMem[i] = '0;
            dataMem[i] = 32'hDA7A_0000 + (i << 2);
        end
        arithmeticOps();
        loadAndStore();
        beqPaths();
        jumpTarget();
        noOpAndZeroReg();
        resetBehavior();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
hdl/MipsIsaPkg.sv
hdl/MipsCtrlPkg.sv
hdl/ControlIf.sv
hdl/ControlUnit.sv
hdl/AluControl.sv
hdl/Alu.sv
hdl/RegisterFile.sv
hdl/MipsCore.sv
verif/ClockGen.sv
verif/MipsCoreTb.sv
